/* logic/mem_pkg.sv */
package mem_pkg;

    // core ports and cache geometry
    localparam int NUM_PORTS  = 2;
    localparam int PORT_W     = $clog2(NUM_PORTS);
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 16;
    localparam int TAG_W      = 24;
    localparam int IDX_W      = 4;
    localparam int WORD_W     = $clog2(LINE_WORDS);

    // segment codes in the top three address bits
    localparam logic [2:0] SEG_KSEG0 = 3'd4;
    localparam logic [2:0] SEG_KSEG1 = 3'd5;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] offset;
    } seg_view_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [IDX_W-1:0]  idx;
        logic [WORD_W-1:0] word;
        logic [1:0]        boff;
    } cache_view_t;

    // one address word, read by the mapper or by the cache
    typedef union packed {
        seg_view_t   seg_view;
        cache_view_t cache_view;
    } vaddr_u;

    typedef struct packed {
        logic        we;
        logic [3:0]  strb;
        vaddr_u      addr;
        logic [31:0] wdata;
    } core_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } core_rsp_t;

    // len is beats minus one
    typedef struct packed {
        logic        write;
        logic [1:0]  len;
        logic [31:0] paddr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } bus_job_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        last;
        logic        done;
    } bus_beat_t;

endpackage

/* logic/addr_map.sv */
`timescale 1ns/1ps

module addr_map
    import mem_pkg::*;
(
    input  logic [NUM_PORTS-1:0] i_req_valid,
    input  core_req_t            i_req [NUM_PORTS],
    output logic [NUM_PORTS-1:0] o_req_valid,
    output core_req_t            o_req [NUM_PORTS],
    output logic [NUM_PORTS-1:0] o_uncached
);

    logic [2:0] seg [NUM_PORTS];

    // strobe needs no translation
    assign o_req_valid = i_req_valid;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            seg[p] = i_req[p].addr.seg_view.seg;
            o_req[p] = i_req[p];
            o_uncached[p] = 1'b0;

            // kseg0 and kseg1 both fold onto low physical memory
            if (seg[p] == SEG_KSEG0 || seg[p] == SEG_KSEG1) begin
                o_req[p].addr.seg_view.seg = 3'b000;
            end

            if (seg[p] == SEG_KSEG1) begin
                o_uncached[p] = 1'b1;
            end
        end
    end

endmodule

/* logic/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache
    import mem_pkg::*;
(
    input  logic      i_aclk,
    input  logic      i_arst_n,
    input  logic      i_req_valid,
    input  core_req_t i_req,
    input  logic      i_uncached,
    output logic      o_rsp_valid,
    output core_rsp_t o_rsp,
    output logic      o_job_valid,
    output bus_job_t  o_job,
    input  logic      i_beat_valid,
    input  bus_beat_t i_beat
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_WAIT_WRITE,
        ST_WAIT_UNCACHED
    } state_t;

    state_t state_q;

    logic [TAG_W-1:0]     tag_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [31:0]          data_q [NUM_LINES][LINE_WORDS];

    vaddr_u            req_addr_q;
    logic [WORD_W-1:0] fill_cnt_q;
    logic              rsp_valid_q;
    core_rsp_t         rsp_q;
    logic              job_valid_q;
    bus_job_t          job_q;

    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  idx;
    logic [WORD_W-1:0] word;
    logic [IDX_W-1:0]  fill_idx;
    logic              accept;
    logic              hit;
    logic              fill_beat;

    assign tag  = i_req.addr.cache_view.tag;
    assign idx  = i_req.addr.cache_view.idx;
    assign word = i_req.addr.cache_view.word;

    assign fill_idx  = req_addr_q.cache_view.idx;
    assign accept    = (state_q == ST_IDLE) && i_req_valid;
    assign hit       = valid_q[idx] && (tag_q[idx] == tag) && !i_uncached;
    assign fill_beat = (state_q == ST_FILL) && i_beat_valid;

    assign o_rsp_valid = rsp_valid_q;
    assign o_rsp       = rsp_q;
    assign o_job_valid = job_valid_q;
    assign o_job       = job_q;

    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= ST_IDLE;
            valid_q     <= '0;
            fill_cnt_q  <= '0;
            rsp_valid_q <= 1'b0;
            job_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            job_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    fill_cnt_q <= '0;
                    if (accept) begin
                        if (i_req.we) begin
                            job_valid_q <= 1'b1;
                            state_q     <= ST_WAIT_WRITE;
                        end else if (hit) begin
                            rsp_valid_q <= 1'b1;
                        end else if (i_uncached) begin
                            job_valid_q <= 1'b1;
                            state_q     <= ST_WAIT_UNCACHED;
                        end else begin
                            // line is rebuilt, drop it until the last beat
                            job_valid_q  <= 1'b1;
                            valid_q[idx] <= 1'b0;
                            state_q      <= ST_FILL;
                        end
                    end
                end
                ST_FILL: begin
                    if (i_beat_valid) begin
                        fill_cnt_q <= fill_cnt_q + 1'b1;
                        if (i_beat.last) begin
                            valid_q[fill_idx] <= 1'b1;
                            rsp_valid_q       <= 1'b1;
                            state_q           <= ST_IDLE;
                        end
                    end
                end
                ST_WAIT_WRITE: begin
                    if (i_beat_valid && i_beat.done) begin
                        rsp_valid_q <= 1'b1;
                        state_q     <= ST_IDLE;
                    end
                end
                ST_WAIT_UNCACHED: begin
                    if (i_beat_valid && i_beat.last) begin
                        rsp_valid_q <= 1'b1;
                        state_q     <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        if (accept) begin
            req_addr_q  <= i_req.addr;
            job_q.write <= i_req.we;
            job_q.wdata <= i_req.wdata;
            job_q.strb  <= i_req.strb;
            if (!i_req.we && !i_uncached) begin
                // whole line, starting at word 0
                job_q.len   <= 2'(LINE_WORDS - 1);
                job_q.paddr <= {tag, idx, {(32 - TAG_W - IDX_W){1'b0}}};
            end else begin
                job_q.len   <= 2'd0;
                job_q.paddr <= i_req.addr;
            end

            if (i_req.we) begin
                rsp_q.rdata <= '0;
                if (hit) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_req.strb[b]) begin
                            data_q[idx][word][8*b +: 8] <= i_req.wdata[8*b +: 8];
                        end
                    end
                end
            end else if (hit) begin
                rsp_q.rdata <= data_q[idx][word];
            end
        end

        if (fill_beat) begin
            data_q[fill_idx][fill_cnt_q] <= i_beat.rdata;
            // catch the requested word as it goes by
            if (fill_cnt_q == req_addr_q.cache_view.word) begin
                rsp_q.rdata <= i_beat.rdata;
            end
            if (i_beat.last) begin
                tag_q[fill_idx] <= req_addr_q.cache_view.tag;
            end
        end

        if (state_q == ST_WAIT_UNCACHED && i_beat_valid) begin
            rsp_q.rdata <= i_beat.rdata;
        end
    end

endmodule

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter
    import mem_pkg::*;
(
    input  logic                 i_aclk,
    input  logic                 i_arst_n,
    input  logic [NUM_PORTS-1:0] i_job_valid,
    input  bus_job_t             i_job [NUM_PORTS],
    output logic [NUM_PORTS-1:0] o_beat_valid,
    output bus_beat_t            o_beat [NUM_PORTS],
    output logic [31:0]          o_araddr,
    output logic [3:0]           o_arlen,
    output logic                 o_arvalid,
    input  logic                 i_arready,
    input  logic [31:0]          i_rdata,
    input  logic                 i_rlast,
    input  logic                 i_rvalid,
    output logic                 o_rready,
    output logic [31:0]          o_awaddr,
    output logic                 o_awvalid,
    input  logic                 i_awready,
    output logic [31:0]          o_wdata,
    output logic [3:0]           o_wstrb,
    output logic                 o_wvalid,
    input  logic                 i_wready,
    input  logic                 i_bvalid,
    output logic                 o_bready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t state_q;

    logic [NUM_PORTS-1:0] pend_q;
    bus_job_t             pend_job_q [NUM_PORTS];
    bus_job_t             cur_q;
    logic [PORT_W-1:0]    grant_q;
    logic                 arvalid_q;
    logic                 awvalid_q;
    logic                 wvalid_q;

    logic              pick_any;
    logic [PORT_W-1:0] pick;
    logic              grant;
    logic              r_fire;
    logic              b_fire;

    // higher port index wins
    always_comb begin
        pick_any = 1'b0;
        pick     = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (pend_q[p]) begin
                pick_any = 1'b1;
                pick     = PORT_W'(p);
            end
        end
    end

    assign grant  = (state_q == ST_IDLE) && pick_any;
    assign r_fire = o_rready && i_rvalid;
    assign b_fire = o_bready && i_bvalid;

    assign o_araddr  = cur_q.paddr;
    assign o_arlen   = {2'b00, cur_q.len};
    assign o_arvalid = arvalid_q;
    assign o_rready  = (state_q == ST_READ);
    assign o_awaddr  = cur_q.paddr;
    assign o_awvalid = awvalid_q;
    assign o_wdata   = cur_q.wdata;
    assign o_wstrb   = cur_q.strb;
    assign o_wvalid  = wvalid_q;
    assign o_bready  = (state_q == ST_WRITE);

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            o_beat_valid[p] = (r_fire || b_fire) && (grant_q == PORT_W'(p));
            o_beat[p].rdata = i_rdata;
            o_beat[p].last  = r_fire && i_rlast;
            o_beat[p].done  = b_fire;
        end
    end

    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= ST_IDLE;
            pend_q    <= '0;
            grant_q   <= '0;
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (i_job_valid[p]) begin
                    pend_q[p] <= 1'b1;
                end else if (grant && pick == PORT_W'(p)) begin
                    pend_q[p] <= 1'b0;
                end
            end

            case (state_q)
                ST_IDLE: begin
                    if (pick_any) begin
                        grant_q <= pick;
                        if (pend_job_q[pick].write) begin
                            awvalid_q <= 1'b1;
                            wvalid_q  <= 1'b1;
                            state_q   <= ST_WRITE;
                        end else begin
                            arvalid_q <= 1'b1;
                            state_q   <= ST_READ;
                        end
                    end
                end
                ST_READ: begin
                    if (arvalid_q && i_arready) begin
                        arvalid_q <= 1'b0;
                    end
                    if (r_fire && i_rlast) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    // aw and w may finish in either order
                    if (awvalid_q && i_awready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (wvalid_q && i_wready) begin
                        wvalid_q <= 1'b0;
                    end
                    if (b_fire) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (i_job_valid[p]) begin
                pend_job_q[p] <= i_job[p];
            end
        end
        if (grant) begin
            cur_q <= pend_job_q[pick];
        end
    end

endmodule

/* logic/mem_top.sv */
`timescale 1ns/1ps

module mem_top
    import mem_pkg::*;
(
    input  logic                 i_aclk,
    input  logic                 i_arst_n,
    input  logic [NUM_PORTS-1:0] i_req_valid,
    input  core_req_t            i_req [NUM_PORTS],
    output logic [NUM_PORTS-1:0] o_rsp_valid,
    output core_rsp_t            o_rsp [NUM_PORTS],
    output logic [31:0]          o_araddr,
    output logic [3:0]           o_arlen,
    output logic                 o_arvalid,
    input  logic                 i_arready,
    input  logic [31:0]          i_rdata,
    input  logic                 i_rlast,
    input  logic                 i_rvalid,
    output logic                 o_rready,
    output logic [31:0]          o_awaddr,
    output logic                 o_awvalid,
    input  logic                 i_awready,
    output logic [31:0]          o_wdata,
    output logic [3:0]           o_wstrb,
    output logic                 o_wvalid,
    input  logic                 i_wready,
    input  logic                 i_bvalid,
    output logic                 o_bready
);

    logic [NUM_PORTS-1:0] map_valid;
    core_req_t            map_req [NUM_PORTS];
    logic [NUM_PORTS-1:0] map_uncached;

    logic [NUM_PORTS-1:0] job_valid;
    bus_job_t             job [NUM_PORTS];
    logic [NUM_PORTS-1:0] beat_valid;
    bus_beat_t            beat [NUM_PORTS];

    addr_map addr_map_i (
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_req_valid (map_valid),
        .o_req       (map_req),
        .o_uncached  (map_uncached)
    );

    // one cache per core port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_cache
        l1_cache l1_cache_i (
            .i_aclk       (i_aclk),
            .i_arst_n     (i_arst_n),
            .i_req_valid  (map_valid[p]),
            .i_req        (map_req[p]),
            .i_uncached   (map_uncached[p]),
            .o_rsp_valid  (o_rsp_valid[p]),
            .o_rsp        (o_rsp[p]),
            .o_job_valid  (job_valid[p]),
            .o_job        (job[p]),
            .i_beat_valid (beat_valid[p]),
            .i_beat       (beat[p])
        );
    end

    bus_arbiter bus_arbiter_i (
        .i_aclk       (i_aclk),
        .i_arst_n     (i_arst_n),
        .i_job_valid  (job_valid),
        .i_job        (job),
        .o_beat_valid (beat_valid),
        .o_beat       (beat),
        .o_araddr     (o_araddr),
        .o_arlen      (o_arlen),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .i_rdata      (i_rdata),
        .i_rlast      (i_rlast),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready),
        .o_awaddr     (o_awaddr),
        .o_awvalid    (o_awvalid),
        .i_awready    (i_awready),
        .o_wdata      (o_wdata),
        .o_wstrb      (o_wstrb),
        .o_wvalid     (o_wvalid),
        .i_wready     (i_wready),
        .i_bvalid     (i_bvalid),
        .o_bready     (o_bready)
    );

endmodule

/* tests/mem_top_properties.sv */
`timescale 1ns/1ps

module mem_top_properties
    import mem_pkg::*;
(
    input logic                 i_aclk,
    input logic                 i_arst_n,
    input logic [NUM_PORTS-1:0] i_req_valid,
    input logic [NUM_PORTS-1:0] o_rsp_valid,
    input logic [31:0]          o_araddr,
    input logic                 o_arvalid,
    input logic                 i_arready,
    input logic                 o_awvalid,
    input logic                 i_awready,
    input logic                 o_wvalid,
    input logic                 i_wready
);

    int unsigned          fail_cnt = 0;
    logic [NUM_PORTS-1:0] busy_q;

    // one request in flight per port
    always_ff @(posedge i_aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q | i_req_valid) & ~o_rsp_valid;
        end
    end

    ar_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
        else begin
            fail_cnt++;
            $error("arvalid or araddr changed before arready");
        end

    aw_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
        o_awvalid && !i_awready |=> o_awvalid)
        else begin
            fail_cnt++;
            $error("awvalid dropped before awready");
        end

    w_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
        o_wvalid && !i_wready |=> o_wvalid)
        else begin
            fail_cnt++;
            $error("wvalid dropped before wready");
        end

    ar_aw_excl: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
        !(o_arvalid && o_awvalid))
        else begin
            fail_cnt++;
            $error("arvalid and awvalid high together");
        end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_rsp
        rsp_owed: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
            o_rsp_valid[p] |-> busy_q[p])
            else begin
                fail_cnt++;
                $error("response on port %0d with no request outstanding", p);
            end
    end

endmodule

bind mem_top mem_top_properties props_i (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_req_valid (i_req_valid),
    .o_rsp_valid (o_rsp_valid),
    .o_araddr    (o_araddr),
    .o_arvalid   (o_arvalid),
    .i_arready   (i_arready),
    .o_awvalid   (o_awvalid),
    .i_awready   (i_awready),
    .o_wvalid    (o_wvalid),
    .i_wready    (i_wready)
);

/* tests/tb_mem_top.sv */
`timescale 1ns/1ps

module tb_mem_top;
    import mem_pkg::*;

    localparam int NUM_REQ        = 100;
    localparam int TIMEOUT_CYCLES = (2 * NUM_REQ + 8) * 40;
    localparam logic [31:0] SHARED_BASE = 32'h0F00_0000;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [3:0]  len;
        logic [31:0] data;
        logic [3:0]  strb;
    } bus_xfer_t;

    logic                 i_aclk = 1'b0;
    logic                 i_arst_n;
    logic [NUM_PORTS-1:0] i_req_valid;
    core_req_t            i_req [NUM_PORTS];
    logic [NUM_PORTS-1:0] o_rsp_valid;
    core_rsp_t            o_rsp [NUM_PORTS];
    logic [31:0]          o_araddr;
    logic [3:0]           o_arlen;
    logic                 o_arvalid;
    logic                 i_arready;
    logic [31:0]          i_rdata;
    logic                 i_rlast;
    logic                 i_rvalid;
    logic                 o_rready;
    logic [31:0]          o_awaddr;
    logic                 o_awvalid;
    logic                 i_awready;
    logic [31:0]          o_wdata;
    logic [3:0]           o_wstrb;
    logic                 o_wvalid;
    logic                 i_wready;
    logic                 i_bvalid;
    logic                 o_bready;

    // reference memory and the memory behind the bus slave
    logic [31:0]          ref_mem [logic [31:0]];
    logic [31:0]          bus_mem [logic [31:0]];
    logic [TAG_W-1:0]     line_tag [NUM_PORTS][NUM_LINES];
    logic [NUM_LINES-1:0] line_ok [NUM_PORTS];
    bus_xfer_t            xfer_log [$];
    bus_xfer_t            rd_q [$];
    logic [31:0]          ar_order [$];
    int                   errors = 0;
    int                   cycles = 0;

    mem_top mem_top_i (.*);

    always #10 i_aclk = ~i_aclk;

    always @(posedge i_aclk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // words never written
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] phys_of(input logic [31:0] va);
        if (va[31:29] == 3'd4 || va[31:29] == 3'd5) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    function automatic logic line_cached(input int p, input logic [31:0] pa);
        return line_ok[p][pa[7:4]] && (line_tag[p][pa[7:4]] == pa[31:8]);
    endfunction

    // kseg0, port 0 low half and port 1 high half
    function automatic logic [31:0] cached_vaddr(input int p, input int w);
        return 32'h8000_0000 + 32'(p) * 32'h1000_0000 + 32'(w) * 4;
    endfunction

    // kseg1 window, words interleaved between the ports
    function automatic logic [31:0] shared_vaddr(input int p, input int k);
        return 32'hA000_0000 + SHARED_BASE + 32'(2 * k + p) * 4;
    endfunction

    function automatic logic [31:0] miss_vaddr(input int p);
        logic [31:0] va;
        va = cached_vaddr(p, $urandom_range(0, 127));
        if (line_cached(p, phys_of(va))) begin
            va[8] = ~va[8];
        end
        return va;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic take_xfer(input logic write, input logic [31:0] addr,
                             output bus_xfer_t x, output logic found);
        found = 1'b0;
        x = '0;
        for (int i = 0; i < xfer_log.size(); i++) begin
            if (!found && xfer_log[i].write == write && xfer_log[i].addr == addr) begin
                x = xfer_log[i];
                xfer_log.delete(i);
                found = 1'b1;
            end
        end
    endtask

    task automatic do_access(input int p, input logic we, input logic [31:0] va,
                             input logic [3:0] strb, input logic [31:0] wdata);
        logic [31:0] pa;
        logic [31:0] line;
        logic [31:0] exp;
        logic        unc;
        logic        hit;
        logic        found;
        bus_xfer_t   x;
        int          lat;
        pa   = phys_of(va);
        line = {pa[31:4], 4'b0000};
        unc  = (va[31:29] == 3'd5);
        hit  = !unc && line_cached(p, pa);
        exp  = '0;
        if (we) begin
            ref_mem[pa] = merge(ref_mem.exists(pa) ? ref_mem[pa] : fill_word(pa), wdata, strb);
        end else begin
            exp = ref_mem.exists(pa) ? ref_mem[pa] : fill_word(pa);
            if (!unc && !hit) begin
                line_ok[p][pa[7:4]]  = 1'b1;
                line_tag[p][pa[7:4]] = pa[31:8];
            end
        end

        @(posedge i_aclk);
        #1;
        i_req_valid[p] = 1'b1;
        i_req[p] = {we, strb, va, wdata};
        @(posedge i_aclk);
        #1;
        i_req_valid[p] = 1'b0;
        lat = 0;
        do begin
            @(negedge i_aclk);
            lat++;
        end while (!o_rsp_valid[p]);
        check_val($sformatf("o_rsp[%0d].rdata", p), o_rsp[p].rdata, exp);

        if (we) begin
            take_xfer(1'b1, pa, x, found);
            if (!found) begin
                errors++;
                $display("port %0d write to %h made no AW/W transfer", p, pa);
            end else begin
                check_val("o_wstrb", x.strb, strb);
                check_val("o_wdata", x.data, wdata);
            end
        end else if (hit) begin
            check_val($sformatf("o_rsp_valid[%0d] latency", p), lat, 1);
        end else begin
            take_xfer(1'b0, unc ? pa : line, x, found);
            if (!found) begin
                errors++;
                $display("port %0d read of %h made no matching AR transfer", p, pa);
            end else begin
                check_val("o_arlen", x.len, unc ? 32'd0 : 32'd3);
            end
        end
    endtask

    task automatic port_traffic(input int p, input int n);
        int          gap;
        int          sel;
        logic [31:0] va;
        for (int k = 0; k < n; k++) begin
            gap = $urandom_range(0, 3);
            repeat (gap) @(posedge i_aclk);
            sel = $urandom_range(0, 9);
            if (sel < 6) begin
                va = cached_vaddr(p, $urandom_range(0, 127));
            end else begin
                va = shared_vaddr(p, $urandom_range(0, 31));
            end
            do_access(p, sel == 4 || sel == 5 || sel == 9, va,
                      4'($urandom_range(1, 15)), $urandom);
        end
    endtask

    initial begin : ar_slave
        bus_xfer_t x;
        forever begin
            @(posedge i_aclk);
            #1;
            if (o_arvalid) begin
                repeat ($urandom_range(0, 3)) begin
                    @(posedge i_aclk);
                    #1;
                end
                x = '0;
                x.addr = o_araddr;
                x.len  = o_arlen;
                i_arready = 1'b1;
                @(posedge i_aclk);
                #1;
                i_arready = 1'b0;
                xfer_log.push_back(x);
                rd_q.push_back(x);
                ar_order.push_back(x.addr);
            end
        end
    end

    initial begin : r_slave
        bus_xfer_t   x;
        logic        rdy;
        logic [31:0] a;
        forever begin
            @(posedge i_aclk);
            #1;
            if (rd_q.size() != 0) begin
                x = rd_q.pop_front();
                for (int b = 0; b <= int'(x.len); b++) begin
                    repeat ($urandom_range(0, 3)) begin
                        @(posedge i_aclk);
                        #1;
                    end
                    a = x.addr + 32'(b) * 4;
                    i_rdata  = bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
                    i_rlast  = (b == int'(x.len));
                    i_rvalid = 1'b1;
                    do begin
                        rdy = o_rready;
                        @(posedge i_aclk);
                        #1;
                    end while (!rdy);
                    i_rvalid = 1'b0;
                    i_rlast  = 1'b0;
                end
            end
        end
    end

    initial begin : w_slave
        bus_xfer_t x;
        logic      rdy;
        logic      vld;
        forever begin
            @(posedge i_aclk);
            #1;
            if (o_awvalid) begin
                x = '0;
                x.write = 1'b1;
                x.addr  = o_awaddr;
                fork
                    begin
                        repeat ($urandom_range(0, 3)) begin
                            @(posedge i_aclk);
                            #1;
                        end
                        i_awready = 1'b1;
                        @(posedge i_aclk);
                        #1;
                        i_awready = 1'b0;
                    end
                    begin
                        repeat ($urandom_range(0, 3)) begin
                            @(posedge i_aclk);
                            #1;
                        end
                        i_wready = 1'b1;
                        // data is taken on the edge where wvalid meets wready
                        do begin
                            vld    = o_wvalid;
                            x.data = o_wdata;
                            x.strb = o_wstrb;
                            @(posedge i_aclk);
                            #1;
                        end while (!vld);
                        i_wready = 1'b0;
                    end
                join
                bus_mem[x.addr] = merge(bus_mem.exists(x.addr) ? bus_mem[x.addr]
                                        : fill_word(x.addr), x.data, x.strb);
                xfer_log.push_back(x);
                repeat ($urandom_range(0, 3)) begin
                    @(posedge i_aclk);
                    #1;
                end
                i_bvalid = 1'b1;
                do begin
                    rdy = o_bready;
                    @(posedge i_aclk);
                    #1;
                end while (!rdy);
                i_bvalid = 1'b0;
            end
        end
    end

    initial begin : main
        logic [31:0] va0;
        logic [31:0] va1;
        void'($urandom(77680));
        i_arst_n    = 1'b0;
        i_req_valid = '0;
        i_arready   = 1'b0;
        i_rdata     = '0;
        i_rlast     = 1'b0;
        i_rvalid    = 1'b0;
        i_awready   = 1'b0;
        i_wready    = 1'b0;
        i_bvalid    = 1'b0;
        foreach (i_req[p]) begin
            i_req[p]   = '0;
            line_ok[p] = '0;
        end
        repeat (4) @(posedge i_aclk);
        #1;
        i_arst_n = 1'b1;

        // simultaneous misses, port 1 goes out first
        for (int k = 0; k < 4; k++) begin
            va0 = miss_vaddr(0);
            va1 = miss_vaddr(1);
            ar_order.delete();
            fork
                do_access(0, 1'b0, va0, 4'hf, '0);
                do_access(1, 1'b0, va1, 4'hf, '0);
            join
            if (ar_order.size() != 2) begin
                errors++;
                $display("simultaneous misses gave %0d AR transfers", ar_order.size());
            end else begin
                check_val("o_araddr first", ar_order[0], phys_of(va1) & 32'hFFFF_FFF0);
                check_val("o_araddr second", ar_order[1], phys_of(va0) & 32'hFFFF_FFF0);
            end
        end

        fork
            port_traffic(0, NUM_REQ);
            port_traffic(1, NUM_REQ);
        join
        repeat (10) @(posedge i_aclk);

        if (xfer_log.size() != 0) begin
            errors++;
            $display("%0d bus transfers matched no request", xfer_log.size());
        end
        if (mem_top_i.props_i.fail_cnt != 0) begin
            errors += int'(mem_top_i.props_i.fail_cnt);
            $display("%0d bus or response assertions failed", mem_top_i.props_i.fail_cnt);
        end
        $display("done: %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
logic/mem_pkg.sv
logic/addr_map.sv
logic/l1_cache.sv
logic/bus_arbiter.sv
logic/mem_top.sv
tests/mem_top_properties.sv
tests/tb_mem_top.sv

/* Makefile */
# Verilator build and run of tb_mem_top

SRCS := $(shell cat files.f)

obj_dir/Vtb_mem_top: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_top \
		--Mdir obj_dir -f files.f

.PHONY: run clean

run: obj_dir/Vtb_mem_top
	@out="$$(./obj_dir/Vtb_mem_top +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
